//--- ttc_lite.f
+incdir+hw
hw/ttc_pkg.sv
hw/ttc_if.sv
hw/ttc_apb_decode.sv
hw/ttc_channel_regs.sv
hw/ttc_count_unit.sv
hw/ttc_lite.sv
testbench/ttc_lite_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module ttc_lite_tb \
		-f ttc_lite.f -o Vttc_lite_tb
	out=$$(./obj_dir/Vttc_lite_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- testbench/ttc_lite_tb.sv
// Triple timer/counter testbench with clock, reset, APB tasks, table checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

module ttc_lite_tb;

   // ----------------------------------------------------------------------
   // Register map as seen from the bus
   // ----------------------------------------------------------------------
   localparam logic [7:0] OFF_CLK      = 8'h00;
   localparam logic [7:0] OFF_CNTR     = 8'h04;
   localparam logic [7:0] OFF_COUNT    = 8'h08;
   localparam logic [7:0] OFF_INTERVAL = 8'h0c;
   localparam logic [7:0] OFF_MATCH1   = 8'h10;
   localparam logic [7:0] OFF_MATCH2   = 8'h14;
   localparam logic [7:0] OFF_MATCH3   = 8'h18;
   localparam logic [7:0] OFF_STAT     = 8'h1c;
   localparam logic [7:0] OFF_EN       = 8'h20;
   localparam int TABLE_LEN = 64;        // Four 0x40 windows of 16 words
   localparam int IVAL      = 20;        // Interval used in the interval tests
   localparam int MVAL      = 7;         // Reachable match value

   typedef struct {
      logic [`TTC_ADDR_W-1:0] addr;
      logic [`TTC_DATA_W-1:0] wdata;
      logic [`TTC_DATA_W-1:0] mask;      // Bits that read back
   } table_entry_t;

   logic                    pclk;
   logic                    reset;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [`TTC_ADDR_W-1:0]  paddr;
   logic [`TTC_DATA_W-1:0]  pwdata;
   logic [`TTC_DATA_W-1:0]  prdata;
   logic [`TTC_NUM_CH-1:0]  interrupt;
   table_entry_t            stim [TABLE_LEN];
   integer                  seed = 32'hde25e985;
   int                      errors = 0;

   ttc_lite ttc_lite_inst (
      .pclk      (pclk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   initial begin
      pclk = 1'b0;
      forever #20 pclk = ~pclk;          // 40 ns period
   end

   // ----------------------------------------------------------------------
   // Bus and reset tasks
   // ----------------------------------------------------------------------
   task automatic apply_reset();
      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (16) @(posedge pclk);
      #2 reset = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge pclk);
      #2 psel = 1'b1;                    // Setup phase
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(posedge pclk);
      #2 penable = 1'b1;                 // Access phase ends at the next edge
      @(posedge pclk);
      #2 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge pclk);
      #2 psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = addr;
      @(posedge pclk);
      #2 penable = 1'b1;
      #10 data = prdata;                 // Sample mid cycle before the clearing edge
      @(posedge pclk);
      #2 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Readable width per word offset
   function automatic logic [31:0] rw_mask(input int off);
      case (off)
         0:             return 32'h1f;   // pre_val and pre_en
         1:             return 32'h0f;   // cnt_rst reads 0
         3, 4, 5, 6:    return 32'hffff;
         8:             return 32'h0f;
         default:       return 32'h0;    // Count, status and holes
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Stimulus table
   // ----------------------------------------------------------------------
   task automatic build_table();
      int idx;
      for (int ch = 0; ch < 4; ch++) begin
         for (int off = 0; off < 16; off++) begin
            idx = ch * 16 + off;
            stim[idx].addr  = 8'(ch * 64 + off * 4);
            stim[idx].wdata = $random(seed);
            if (off == 1)
               stim[idx].wdata[0] = 1'b1;   // Keep the counter stopped
            stim[idx].mask = (ch < 3) ? rw_mask(off) : 32'h0;  // Window 3 is empty
         end
      end
   endtask

   task automatic run_table();
      logic [31:0] rd;
      for (int i = 0; i < TABLE_LEN; i++) begin
         apb_write(stim[i].addr, stim[i].wdata);
         apb_read(stim[i].addr, rd);
         compare_value($sformatf("read-back at %h", stim[i].addr), rd,
                       stim[i].wdata & stim[i].mask);
      end
   endtask

   task automatic check_reset_values();
      logic [31:0] rd;
      for (int ch = 0; ch < 3; ch++) begin
         for (int off = 0; off < 16; off++) begin
            apb_read(8'(ch * 64 + off * 4), rd);
            compare_value($sformatf("reset value ch%0d word %0d", ch, off), rd,
                          (off == 1) ? 32'h1 : 32'h0);
         end
      end
      compare_value("interrupt after reset", 32'(interrupt), 32'h0);
   endtask

   // Overflow mode on channel 0 with prescaler exponent 2
   task automatic check_stop_and_count();
      logic [31:0] c0;
      logic [31:0] c1;
      int          p;
      int          w;
      int          exp;
      p = 2;
      w = 800;
      exp = w / (1 << (p + 1));
      apb_read(OFF_COUNT, c0);
      repeat (200) @(posedge pclk);
      apb_read(OFF_COUNT, c1);
      compare_value("count while stopped", c1, c0);
      apb_write(OFF_CLK, 32'((p << 1) | 1));
      apb_write(OFF_CNTR, 32'h11);        // Reload while stopped
      apb_write(OFF_CNTR, 32'h00);        // Count up in overflow mode
      repeat (w) @(posedge pclk);
      apb_write(OFF_CNTR, 32'h01);
      apb_read(OFF_COUNT, c1);
      assert ((int'(c1) >= exp - 2) && (int'(c1) <= exp + 2)) else begin
         errors++;
         $display("[ERROR] %0t ns: prescaled count %0d, expected %0d +/- 2",
                  $time, c1, exp);
      end
   endtask

   // ----------------------------------------------------------------------
   // Interval mode with one reachable and two unreachable match values
   // ----------------------------------------------------------------------
   task automatic run_interval_case(input int ch, input bit down, input logic [3:0] en);
      logic [7:0]  base;
      logic [31:0] rd;
      logic [31:0] ctrl;
      logic [3:0]  exp_stat;
      base = 8'(ch * 64);
      ctrl = 32'h0a | (down ? 32'h04 : 32'h0);  // Interval mode and match enable
      exp_stat = 4'b0011;                      // Wrap and match1 only
      apb_write(base + OFF_INTERVAL, IVAL);
      apb_write(base + OFF_MATCH1, MVAL);
      apb_write(base + OFF_MATCH2, IVAL + 5);  // Beyond the interval
      apb_write(base + OFF_MATCH3, IVAL + 9);
      apb_write(base + OFF_EN, 32'(en));
      apb_write(base + OFF_CLK, 32'h0);        // Tick every cycle
      apb_write(base + OFF_CNTR, ctrl | 32'h11);
      apb_write(base + OFF_CNTR, ctrl);
      for (int i = 0; i < 10; i++) begin
         apb_read(base + OFF_COUNT, rd);
         assert (rd <= IVAL) else begin
            errors++;
            $display("[ERROR] %0t ns: ch%0d count %0d above interval", $time, ch, rd);
         end
      end
      compare_value($sformatf("ch%0d interrupt while running", ch),
                    32'(interrupt[ch]), 32'(|(exp_stat & en)));
      apb_write(base + OFF_CNTR, ctrl | 32'h01);   // Stop
      apb_read(base + OFF_STAT, rd);
      compare_value($sformatf("ch%0d status", ch), rd, 32'(exp_stat));
      apb_read(base + OFF_STAT, rd);
      compare_value($sformatf("ch%0d status after clear", ch), rd, 32'h0);
      compare_value($sformatf("ch%0d interrupt after clear", ch),
                    32'(interrupt[ch]), 32'h0);
      // Other channels stay quiet
      for (int j = 0; j < 3; j++) begin
         if (j != ch) begin
            compare_value($sformatf("ch%0d interrupt idle", j), 32'(interrupt[j]), 32'h0);
            apb_read(8'(j * 64) + OFF_STAT, rd);
            compare_value($sformatf("ch%0d status idle", j), rd, 32'h0);
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      apply_reset();
      check_reset_values();
      build_table();
      run_table();
      apply_reset();                     // Clean state for counting
      check_stop_and_count();
      run_interval_case(1, 1'b0, 4'h1);  // Up with wrap enabled
      run_interval_case(2, 1'b1, 4'h1);  // Down with wrap enabled
      run_interval_case(0, 1'b0, 4'h4);  // Only an unreachable bit enabled
      $display("Checks done, %0d error(s)", errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // Watchdog sized from the table plus the counting tests
   initial begin
      #((TABLE_LEN * 10 + 20000) * 40);
      $display("Timeout: the tests did not finish in time");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/ttc_lite.sv
// Triple timer/counter top level with APB slave and three channels
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

module ttc_lite (
   input  wire                     pclk,
   input  wire                     reset,
   input  wire                     psel,
   input  wire                     penable,
   input  wire                     pwrite,
   input  wire  [`TTC_ADDR_W-1:0]  paddr,
   input  wire  [`TTC_DATA_W-1:0]  pwdata,
   output logic [`TTC_DATA_W-1:0]  prdata,
   output logic [`TTC_NUM_CH-1:0]  interrupt   // One line per channel
);

   // ----------------------------------------------------------------------
   // Per-channel bundles
   // ----------------------------------------------------------------------
   ttc_reg_if reg_if [`TTC_NUM_CH] ();   // Decoder side
   ttc_cfg_if cfg_if [`TTC_NUM_CH] ();   // Regs to counter

   // APB slave, all three channels share one decoder
   ttc_apb_decode decode_inst (
      .pclk    (pclk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .ch0     (reg_if[0]),
      .ch1     (reg_if[1]),
      .ch2     (reg_if[2])
   );

   // ----------------------------------------------------------------------
   // Channels
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < `TTC_NUM_CH; i++) begin : g_ch

      // Register file and interrupt line
      ttc_channel_regs regs_inst (
         .pclk      (pclk),
         .reset     (reset),
         .bus       (reg_if[i]),
         .cfg       (cfg_if[i]),
         .interrupt (interrupt[i])
      );

      // Prescaler and counter
      ttc_count_unit count_inst (
         .pclk  (pclk),
         .reset (reset),
         .cfg   (cfg_if[i])
      );

   end

endmodule

`default_nettype wire

//--- hw/ttc_count_unit.sv
// Prescaler, 16-bit up/down counter, wrap and match event logic for one channel
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

module ttc_count_unit (
   input  wire       pclk,
   input  wire       reset,
   ttc_cfg_if.count  cfg
);

   logic [`TTC_PRE_W:0]   pre_sh;      // Exponent plus one
   logic [`TTC_CNT_W-1:0] pre_last;    // Terminal prescale count
   logic [`TTC_CNT_W-1:0] pre_cnt_q;
   logic                  tick;        // Prescaler terminal
   logic                  tick_en;     // Counter really moves
   logic [`TTC_CNT_W-1:0] cnt_q;
   logic [`TTC_CNT_W-1:0] cnt_next;
   logic [`TTC_CNT_W-1:0] cnt_load;    // Reload value
   logic                  wrap;

   // ----------------------------------------------------------------------
   // Prescaler
   // ----------------------------------------------------------------------
   assign pre_sh   = {1'b0, cfg.clk_ctrl.pre_val} + 1'b1;
   assign pre_last = ~({`TTC_CNT_W{1'b1}} << pre_sh);  // 2^(p+1) - 1

   // >= covers a smaller exponent written mid-count
   assign tick    = ~cfg.clk_ctrl.pre_en | (pre_cnt_q >= pre_last);
   assign tick_en = tick & ~cfg.cntr_ctrl.stop & ~cfg.cnt_rst;

   // ----------------------------------------------------------------------
   // Next count and wrap detect
   // ----------------------------------------------------------------------
   always_comb begin
      wrap = 1'b0;
      if (cfg.cntr_ctrl.decrement) begin
         cnt_next = cnt_q - 1'b1;
         if (cnt_q == '0) begin
            wrap     = 1'b1;
            cnt_next = cfg.cntr_ctrl.interval_mode ? cfg.interval : '1;
         end
      end else begin
         cnt_next = cnt_q + 1'b1;           // 0xFFFF rolls to 0
         if (cfg.cntr_ctrl.interval_mode && (cnt_q >= cfg.interval)) begin
            wrap     = 1'b1;
            cnt_next = '0;
         end else if (cnt_q == '1) begin
            wrap = 1'b1;
         end
      end
   end

   // Down-interval restarts from the top
   assign cnt_load = (cfg.cntr_ctrl.decrement && cfg.cntr_ctrl.interval_mode) ?
                     cfg.interval : '0;

   always_ff @(posedge pclk) begin
      if (reset) begin
         cnt_q     <= '0;
         pre_cnt_q <= '0;
      end else if (cfg.cnt_rst) begin
         cnt_q     <= cnt_load;
         pre_cnt_q <= '0;                   // Prescaler restarts too
      end else if (!cfg.cntr_ctrl.stop) begin
         pre_cnt_q <= tick ? '0 : pre_cnt_q + 1'b1;
         if (tick)
            cnt_q <= cnt_next;
      end
   end

   // ----------------------------------------------------------------------
   // Events in the cycle of the moving tick
   // ----------------------------------------------------------------------
   always_comb begin
      cfg.events                      = '0;
      cfg.events[ttc_pkg::IRQ_WRAP]   = tick_en & wrap;
      cfg.events[ttc_pkg::IRQ_MATCH1] = tick_en & cfg.cntr_ctrl.match_en &
                                        (cnt_next == cfg.match1);
      cfg.events[ttc_pkg::IRQ_MATCH2] = tick_en & cfg.cntr_ctrl.match_en &
                                        (cnt_next == cfg.match2);
      cfg.events[ttc_pkg::IRQ_MATCH3] = tick_en & cfg.cntr_ctrl.match_en &
                                        (cnt_next == cfg.match3);
   end

   assign cfg.count_val = cnt_q;

   // An event restarts the prescaler and the counter lands on the value it saw
   a_event_on_tick : assert property (@(posedge pclk) disable iff (reset)
      (|cfg.events) |=> (pre_cnt_q == '0) && (cfg.count_val == $past(cnt_next)));

endmodule

`default_nettype wire

//--- hw/ttc_channel_regs.sv
// Per-channel control, interval, match, interrupt status and enable registers
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

module ttc_channel_regs (
   input  wire         pclk,
   input  wire         reset,
   ttc_reg_if.regs     bus,
   ttc_cfg_if.regs     cfg,
   output logic        interrupt
);

   localparam int CLK_W  = $bits(ttc_pkg::clk_ctrl_t);
   localparam int CNTR_W = $bits(ttc_pkg::cntr_ctrl_t);

   ttc_pkg::clk_ctrl_t    clk_ctrl_q;
   ttc_pkg::cntr_ctrl_t   cntr_ctrl_q;
   ttc_pkg::cntr_ctrl_t   cntr_wdata;     // Write data seen as counter control
   logic [`TTC_CNT_W-1:0] interval_q;
   logic [`TTC_CNT_W-1:0] match1_q;
   logic [`TTC_CNT_W-1:0] match2_q;
   logic [`TTC_CNT_W-1:0] match3_q;
   logic [`TTC_IRQ_W-1:0] irq_stat_q;
   logic [`TTC_IRQ_W-1:0] irq_en_q;
   logic                  cnt_rst_q;

   assign cntr_wdata = ttc_pkg::cntr_ctrl_t'(bus.wdata[CNTR_W-1:0]);

   // ----------------------------------------------------------------------
   // Register writes and status capture
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (reset) begin
         clk_ctrl_q  <= '0;
         cntr_ctrl_q <= '{stop: 1'b1, default: 1'b0};  // Counter halted
         interval_q  <= '0;
         match1_q    <= '0;
         match2_q    <= '0;
         match3_q    <= '0;
         irq_en_q    <= '0;
         irq_stat_q  <= '0;
         cnt_rst_q   <= 1'b0;
      end else begin
         if (bus.wr) begin
            case (bus.offset)
               ttc_pkg::REG_CLK_CTRL:  clk_ctrl_q <= ttc_pkg::clk_ctrl_t'(bus.wdata[CLK_W-1:0]);
               ttc_pkg::REG_CNTR_CTRL: begin
                  cntr_ctrl_q         <= cntr_wdata;
                  cntr_ctrl_q.cnt_rst <= 1'b0;    // Strobe bit not kept
               end
               ttc_pkg::REG_INTERVAL:  interval_q <= bus.wdata;
               ttc_pkg::REG_MATCH1:    match1_q   <= bus.wdata;
               ttc_pkg::REG_MATCH2:    match2_q   <= bus.wdata;
               ttc_pkg::REG_MATCH3:    match3_q   <= bus.wdata;
               ttc_pkg::REG_IRQ_EN:    irq_en_q   <= bus.wdata[`TTC_IRQ_W-1:0];
               default: ;                         // Count, status, holes
            endcase
         end

         // Reload reaches the counter one cycle after the write
         cnt_rst_q <= bus.wr && (bus.offset == ttc_pkg::REG_CNTR_CTRL) && cntr_wdata.cnt_rst;

         // New events beat a clearing read
         irq_stat_q <= (bus.rd_clr ? '0 : irq_stat_q) | cfg.events;
      end
   end

   // ----------------------------------------------------------------------
   // Config out to the counting logic
   // ----------------------------------------------------------------------
   assign cfg.clk_ctrl  = clk_ctrl_q;
   assign cfg.cntr_ctrl = cntr_ctrl_q;
   assign cfg.interval  = interval_q;
   assign cfg.match1    = match1_q;
   assign cfg.match2    = match2_q;
   assign cfg.match3    = match3_q;
   assign cfg.cnt_rst   = cnt_rst_q;

   // Read-back, status shows pre-clear value
   always_comb begin
      case (bus.offset)
         ttc_pkg::REG_CLK_CTRL:  bus.rdata = `TTC_CNT_W'(clk_ctrl_q);
         ttc_pkg::REG_CNTR_CTRL: bus.rdata = `TTC_CNT_W'(cntr_ctrl_q);
         ttc_pkg::REG_COUNT:     bus.rdata = cfg.count_val;
         ttc_pkg::REG_INTERVAL:  bus.rdata = interval_q;
         ttc_pkg::REG_MATCH1:    bus.rdata = match1_q;
         ttc_pkg::REG_MATCH2:    bus.rdata = match2_q;
         ttc_pkg::REG_MATCH3:    bus.rdata = match3_q;
         ttc_pkg::REG_IRQ_STAT:  bus.rdata = `TTC_CNT_W'(irq_stat_q);
         ttc_pkg::REG_IRQ_EN:    bus.rdata = `TTC_CNT_W'(irq_en_q);
         default:                bus.rdata = '0;  // Unused offsets
      endcase
   end

   assign interrupt = |(irq_stat_q & irq_en_q);  // Straight from flops

   // Decoder only strobes one kind of access per transfer
   a_wr_clr_excl : assert property (@(posedge pclk) disable iff (reset)
      !(bus.wr && bus.rd_clr));

endmodule

`default_nettype wire

//--- hw/ttc_apb_decode.sv
// APB address decode, per-channel write and clear strobes, read data mux
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

module ttc_apb_decode (
   input  wire                    pclk,
   input  wire                    reset,
   input  wire                    psel,
   input  wire                    penable,
   input  wire                    pwrite,
   input  wire [`TTC_ADDR_W-1:0]  paddr,
   input  wire [`TTC_DATA_W-1:0]  pwdata,
   output logic [`TTC_DATA_W-1:0] prdata,
   ttc_reg_if.decode              ch0,
   ttc_reg_if.decode              ch1,
   ttc_reg_if.decode              ch2
);

   logic                   access;      // Second cycle of a transfer
   logic [1:0]             ch_sel;      // Window from paddr[7:6]
   ttc_pkg::ttc_reg_e      offset;      // Word from paddr[5:2]
   logic [`TTC_NUM_CH-1:0] ch_hit;      // Window 3 hits nothing
   logic                   wr_any;
   logic                   clr_any;     // Status read in its access cycle
   logic [`TTC_NUM_CH-1:0] strobe;
   logic [`TTC_CNT_W-1:0]  rdata_sel;

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   assign access  = psel & penable;
   assign ch_sel  = paddr[7:6];
   assign offset  = ttc_pkg::ttc_reg_e'(paddr[5:2]);
   assign ch_hit  = {ch_sel == 2'd2, ch_sel == 2'd1, ch_sel == 2'd0};
   assign wr_any  = access & pwrite;
   assign clr_any = access & ~pwrite & (offset == ttc_pkg::REG_IRQ_STAT);

   // Strobes gated to the addressed channel
   assign ch0.wr     = wr_any & ch_hit[0];
   assign ch0.rd_clr = clr_any & ch_hit[0];
   assign ch0.offset = offset;
   assign ch0.wdata  = pwdata[`TTC_CNT_W-1:0];   // Registers are 16 bits at most

   assign ch1.wr     = wr_any & ch_hit[1];
   assign ch1.rd_clr = clr_any & ch_hit[1];
   assign ch1.offset = offset;
   assign ch1.wdata  = pwdata[`TTC_CNT_W-1:0];

   assign ch2.wr     = wr_any & ch_hit[2];
   assign ch2.rd_clr = clr_any & ch_hit[2];
   assign ch2.offset = offset;
   assign ch2.wdata  = pwdata[`TTC_CNT_W-1:0];

   // ----------------------------------------------------------------------
   // Read data
   // ----------------------------------------------------------------------
   always_comb begin
      case (ch_sel)
         2'd0:    rdata_sel = ch0.rdata;
         2'd1:    rdata_sel = ch1.rdata;
         2'd2:    rdata_sel = ch2.rdata;
         default: rdata_sel = '0;           // Empty window
      endcase
   end

   assign prdata = psel ? `TTC_DATA_W'(rdata_sel) : '0;  // Zero extended

   assign strobe = {ch2.wr | ch2.rd_clr, ch1.wr | ch1.rd_clr, ch0.wr | ch0.rd_clr};

   // One channel per transfer, and only after a setup cycle on the same address
   a_one_strobe : assert property (@(posedge pclk) disable iff (reset)
      (|strobe) |-> $onehot0(strobe) && $past(psel && !penable) && $stable(paddr));

endmodule

`default_nettype wire

//--- hw/ttc_if.sv
// ttc_reg_if register access bundle and ttc_cfg_if channel config bundle
`timescale 1ns/1ps
`default_nettype none

`include "ttc_macros.svh"

// ----------------------------------------------------------------------
// Decoder to channel register block
// ----------------------------------------------------------------------
interface ttc_reg_if;
   logic                  wr;       // Write strobe, one cycle
   logic                  rd_clr;   // Status read, clears on this edge
   ttc_pkg::ttc_reg_e     offset;
   logic [`TTC_CNT_W-1:0] wdata;
   logic [`TTC_CNT_W-1:0] rdata;    // Zero extended by the decoder

   modport decode (output wr, rd_clr, offset, wdata, input rdata);
   modport regs   (input wr, rd_clr, offset, wdata, output rdata);
endinterface

// ----------------------------------------------------------------------
// Register block to counting logic
// ----------------------------------------------------------------------
interface ttc_cfg_if;
   ttc_pkg::clk_ctrl_t    clk_ctrl;
   ttc_pkg::cntr_ctrl_t   cntr_ctrl;
   logic [`TTC_CNT_W-1:0] interval;
   logic [`TTC_CNT_W-1:0] match1;
   logic [`TTC_CNT_W-1:0] match2;
   logic [`TTC_CNT_W-1:0] match3;
   logic                  cnt_rst;    // Reload pulse
   logic [`TTC_CNT_W-1:0] count_val;
   logic [`TTC_IRQ_W-1:0] events;     // Indexed by ttc_irq_e

   modport regs (
      output clk_ctrl, cntr_ctrl, interval, match1, match2, match3, cnt_rst,
      input  count_val, events
   );
   modport count (
      input  clk_ctrl, cntr_ctrl, interval, match1, match2, match3, cnt_rst,
      output count_val, events
   );
endinterface

`default_nettype wire

//--- hw/ttc_pkg.sv
// Register offset enum, interrupt bit enum and control register structs
`default_nettype none

package ttc_pkg;

   `include "ttc_macros.svh"

   // ----------------------------------------------------------------------
   // Register offsets, word index from paddr[5:2]
   // ----------------------------------------------------------------------
   typedef enum logic [3:0] {
      REG_CLK_CTRL  = 4'd0,
      REG_CNTR_CTRL = 4'd1,
      REG_COUNT     = 4'd2,   // Read only
      REG_INTERVAL  = 4'd3,
      REG_MATCH1    = 4'd4,
      REG_MATCH2    = 4'd5,
      REG_MATCH3    = 4'd6,
      REG_IRQ_STAT  = 4'd7,   // Cleared by read
      REG_IRQ_EN    = 4'd8
   } ttc_reg_e;

   // Bit positions in irq status and enable
   typedef enum logic [1:0] {
      IRQ_WRAP   = 2'd0,      // Overflow or interval end
      IRQ_MATCH1 = 2'd1,
      IRQ_MATCH2 = 2'd2,
      IRQ_MATCH3 = 2'd3
   } ttc_irq_e;

   // Clock control, pre_en in bit 0
   typedef struct packed {
      logic [`TTC_PRE_W-1:0] pre_val;  // Tick every 2^(pre_val+1) cycles
      logic                  pre_en;
   } clk_ctrl_t;

   // Counter control, stop in bit 0
   typedef struct packed {
      logic cnt_rst;        // Reload strobe, never stored
      logic match_en;
      logic decrement;
      logic interval_mode;
      logic stop;           // Counter halted, set out of reset
   } cntr_ctrl_t;

endpackage

`default_nettype wire

//--- hw/ttc_macros.svh
// Width and map constants for the triple timer/counter
`ifndef TTC_MACROS_SVH
`define TTC_MACROS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
`define TTC_CNT_W   16   // Counter, interval and match width
`define TTC_PRE_W   4    // Prescaler exponent width
`define TTC_IRQ_W   4    // Interrupt status / enable width

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
`define TTC_NUM_CH  3    // Channels at 0x00, 0x40, 0x80
`define TTC_DATA_W  32   // APB data bus
`define TTC_ADDR_W  8    // APB address bus

`endif
